/* rtl/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1c000000

// most stale responses allowed in flight
// requests stop while the stale count sits at this value
`define FETCH_MAX_STALE 2'd3

// exception code for a fetch address error
`define FETCH_ECODE_ADEF 6'h08

`endif

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // redirect requests from later stages, highest priority first
    typedef struct packed {
        logic        excp_taken;
        logic [31:0] eentry;
        logic        ertn_taken;
        logic [31:0] era;
        logic        br_taken;
        logic [31:0] br_target;
    } redirect_t;

    // one fetched bundle handed to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        adef;
        logic [5:0]  ecode;
    } fetch_bundle_t;

    // instruction memory address phase
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } imem_req_t;

    // instruction memory handshake and data phase
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } imem_resp_t;

endpackage

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  redirect_t   redirect,
    input  logic        advance,
    output logic [31:0] pc,
    output logic        pc_misaligned
);

    logic        redirect_any;
    logic [31:0] redirect_pc;
    logic [31:0] pc_q;

    assign redirect_any = redirect.excp_taken || redirect.ertn_taken || redirect.br_taken;

    // exception entry beats exception return beats branch
    always_comb begin
        if (redirect.excp_taken) begin
            redirect_pc = redirect.eentry;
        end else if (redirect.ertn_taken) begin
            redirect_pc = redirect.era;
        end else begin
            redirect_pc = redirect.br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (redirect_any) begin
            pc_q <= redirect_pc;
        end else if (advance) begin
            // sequential fetch
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc            = pc_q;
    assign pc_misaligned = pc_q[1:0] != 2'b00;

endmodule

/* rtl/fetch_req_fsm.sv */
`timescale 1ns/1ps

module fetch_req_fsm
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect_any,
    input  logic [31:0] pc,
    input  logic        pc_misaligned,
    input  logic        buf_ready,
    input  logic        stale_full,
    input  logic        resp_live,
    output imem_req_t   imem_req,
    input  logic        addr_ok,
    output logic        advance,
    output logic        issue_live,
    output logic        push_adef,
    output logic [31:0] live_pc,
    output logic        in_flight
);

    typedef enum logic [1:0] {
        ST_REQ  = 2'd0,
        ST_WAIT = 2'd1,
        ST_HALT = 2'd2
    } state_t;

    state_t      state;
    state_t      state_next;
    logic [31:0] live_pc_q;
    logic        accepted;

    // only ask for a word the buffer will be able to hold on return
    assign imem_req.req  = !reset && (state == ST_REQ) && !pc_misaligned && !stale_full
                           && buf_ready;
    assign imem_req.addr = pc;

    assign accepted   = imem_req.req && addr_ok;
    assign issue_live = accepted && !redirect_any;
    assign advance    = issue_live;
    assign push_adef  = (state == ST_REQ) && pc_misaligned && buf_ready && !redirect_any;

    // pending request, or one handed over this cycle
    assign in_flight = (state == ST_WAIT) || accepted;

    // while idle in REQ the bundle pc is the current pc (adef case)
    assign live_pc = (state == ST_WAIT) ? live_pc_q : pc;

    always_comb begin
        state_next = state;
        if (redirect_any) begin
            // any pending live request turns stale here
            state_next = ST_REQ;
        end else begin
            case (state)
                ST_REQ: begin
                    if (push_adef) begin
                        state_next = ST_HALT;
                    end else if (issue_live) begin
                        state_next = ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (resp_live) begin
                        state_next = ST_REQ;
                    end
                end
                ST_HALT: begin
                    state_next = ST_HALT;
                end
                default: begin
                    state_next = ST_REQ;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_REQ;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_live) begin
            live_pc_q <= pc;
        end
    end

endmodule

/* rtl/fetch_stale_cnt.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_stale_cnt (
    input  logic clk,
    input  logic reset,
    input  logic redirect_any,
    input  logic in_flight,
    input  logic data_ok,
    output logic stale_full,
    output logic resp_live
);

    logic [1:0] stale_count;
    logic       add_stale;
    logic       drop_stale;

    // responses come back in order, so stale ones are always the oldest
    assign resp_live  = data_ok && (stale_count == 2'd0);
    assign drop_stale = data_ok && (stale_count != 2'd0);

    // live response returning right now is not left behind
    assign add_stale = redirect_any && in_flight && !resp_live;

    always_ff @(posedge clk) begin
        if (reset) begin
            stale_count <= 2'd0;
        end else if (add_stale && !drop_stale) begin
            stale_count <= stale_count + 2'd1;
        end else if (drop_stale && !add_stale) begin
            stale_count <= stale_count - 2'd1;
        end
    end

    assign stale_full = stale_count == `FETCH_MAX_STALE;

endmodule

/* rtl/fetch_inst_buf.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_inst_buf
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          redirect_any,
    input  logic          resp_live,
    input  logic [31:0]   rdata,
    input  logic [31:0]   live_pc,
    input  logic          push_adef,
    output logic          buf_ready,
    output logic          fs_to_ds_valid,
    output fetch_bundle_t fs_to_ds_bundle,
    input  logic          ds_allowin
);

    logic          buf_valid;
    fetch_bundle_t buf_bundle;

    // empty, or handing its bundle to decode this cycle
    assign buf_ready = !buf_valid || ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (redirect_any) begin
            buf_valid <= 1'b0;
        end else if (resp_live || push_adef) begin
            buf_valid <= 1'b1;
        end else if (ds_allowin) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_live) begin
            buf_bundle <= '{pc: live_pc, inst: rdata, adef: 1'b0, ecode: 6'd0};
        end else if (push_adef) begin
            // address error bundle carries no instruction
            buf_bundle <= '{pc: live_pc, inst: 32'd0, adef: 1'b1, ecode: `FETCH_ECODE_ADEF};
        end
    end

    // flushed bundle never reaches decode
    assign fs_to_ds_valid  = buf_valid && !redirect_any;
    assign fs_to_ds_bundle = buf_bundle;

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  redirect_t     redirect,
    output imem_req_t     imem_req,
    input  imem_resp_t    imem_resp,
    output logic          fs_to_ds_valid,
    output fetch_bundle_t fs_to_ds_bundle,
    input  logic          ds_allowin
);

    logic        redirect_any;
    logic [31:0] pc;
    logic        pc_misaligned;
    logic        advance;
    logic        push_adef;
    logic [31:0] live_pc;
    logic        in_flight;
    logic        stale_full;
    logic        resp_live;
    logic        buf_ready;

    assign redirect_any = redirect.excp_taken || redirect.ertn_taken || redirect.br_taken;

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .redirect      (redirect),
        .advance       (advance),
        .pc            (pc),
        .pc_misaligned (pc_misaligned)
    );

    fetch_req_fsm u_req_fsm (
        .clk           (clk),
        .reset         (reset),
        .redirect_any  (redirect_any),
        .pc            (pc),
        .pc_misaligned (pc_misaligned),
        .buf_ready     (buf_ready),
        .stale_full    (stale_full),
        .resp_live     (resp_live),
        .imem_req      (imem_req),
        .addr_ok       (imem_resp.addr_ok),
        .advance       (advance),
        .issue_live    (),
        .push_adef     (push_adef),
        .live_pc       (live_pc),
        .in_flight     (in_flight)
    );

    fetch_stale_cnt u_stale_cnt (
        .clk          (clk),
        .reset        (reset),
        .redirect_any (redirect_any),
        .in_flight    (in_flight),
        .data_ok      (imem_resp.data_ok),
        .stale_full   (stale_full),
        .resp_live    (resp_live)
    );

    fetch_inst_buf u_inst_buf (
        .clk             (clk),
        .reset           (reset),
        .redirect_any    (redirect_any),
        .resp_live       (resp_live),
        .rdata           (imem_resp.rdata),
        .live_pc         (live_pc),
        .push_adef       (push_adef),
        .buf_ready       (buf_ready),
        .fs_to_ds_valid  (fs_to_ds_valid),
        .fs_to_ds_bundle (fs_to_ds_bundle),
        .ds_allowin      (ds_allowin)
    );

endmodule

/* verif/fetch_assert.sv */
`timescale 1ns/1ps

module fetch_assert
    import fetch_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input redirect_t     redirect,
    input imem_req_t     imem_req,
    input imem_resp_t    imem_resp,
    input logic          fs_to_ds_valid,
    input fetch_bundle_t fs_to_ds_bundle,
    input logic          ds_allowin,
    input logic          stale_full
);

    logic redirect_any;
    int   fail_count;

    initial fail_count = 0;

    assign redirect_any = redirect.excp_taken || redirect.ertn_taken || redirect.br_taken;

    task automatic record_failure(input string what);
        fail_count = fail_count + 1;
        $error("%s", what);
    endtask

    // address held until memory takes it
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        imem_req.req && !imem_resp.addr_ok && !redirect_any |=> $stable(imem_req.addr))
        else record_failure("request address changed before addr_ok");

    // flushed bundle never offered to decode
    no_valid_on_redirect: assert property (@(posedge clk) disable iff (reset)
        redirect_any |-> !fs_to_ds_valid)
        else record_failure("fs_to_ds_valid high in a redirect cycle");

    bundle_held: assert property (@(posedge clk) disable iff (reset)
        fs_to_ds_valid && !ds_allowin |=> $stable(fs_to_ds_bundle))
        else record_failure("bundle changed while decode stalled");

    // too many stale responses outstanding
    no_req_when_full: assert property (@(posedge clk) disable iff (reset)
        stale_full |-> !imem_req.req)
        else record_failure("request raised while stale count is full");

endmodule

bind fetch_unit fetch_assert u_assert (.*);

/* verif/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int          NUM_CYCLES  = 4000;
    localparam int          STALL_LIMIT = 200;
    localparam logic [31:0] INST_MASK   = 32'h5a5a5a5a;

    logic          clk;
    logic          reset;
    redirect_t     redirect;
    imem_req_t     imem_req;
    imem_resp_t    imem_resp;
    logic          fs_to_ds_valid;
    fetch_bundle_t fs_to_ds_bundle;
    logic          ds_allowin;

    // addresses memory has taken, and the cycle each may answer
    logic [31:0] pend_addr[$];
    logic [31:0] pend_ready[$];
    logic [31:0] cyc;
    logic [31:0] exp_pc;
    logic        exp_halted;
    logic        timed_out;
    int          mismatches;
    int          other_errors;
    int          bundles_seen;
    int          stall_count;

    fetch_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_bundle(input string name, input fetch_bundle_t exp_b,
                                input fetch_bundle_t act_b);
        if (act_b !== exp_b) begin
            mismatches = mismatches + 1;
            $display("mismatch %s: expected %h_%h_%b_%h, actual %h_%h_%b_%h", name,
                     exp_b.pc, exp_b.inst, exp_b.adef, exp_b.ecode,
                     act_b.pc, act_b.inst, act_b.adef, act_b.ecode);
        end
    endtask

    // nothing goes to memory or decode while reset is held
    task automatic check_quiet_in_reset();
        if (imem_req.req !== 1'b0 || fs_to_ds_valid !== 1'b0) begin
            other_errors = other_errors + 1;
            $display("memory request or decode valid raised while reset is held");
        end
    endtask

    task automatic drive_inputs();
        logic        burst;
        logic [31:0] align_mask;
        burst      = (cyc % 64) < 10;
        // now and then a misaligned target
        align_mask = (($urandom % 8) == 0) ? 32'hffffffff : 32'hfffffffc;
        redirect           = '0;
        redirect.eentry    = $urandom & align_mask;
        redirect.era       = $urandom & align_mask;
        redirect.br_target = $urandom & align_mask;
        // redirects come in short bursts every 64 cycles
        if (($urandom % (burst ? 2 : 16)) == 0) begin
            redirect.excp_taken = ($urandom % 3) == 0;
            redirect.ertn_taken = ($urandom % 3) == 0;
            redirect.br_taken   = ($urandom % 2) == 0
                                  || !(redirect.excp_taken || redirect.ertn_taken);
        end
        imem_resp.addr_ok = ($urandom % 4) != 0;
        imem_resp.data_ok = 1'b0;
        imem_resp.rdata   = $urandom;
        // in order, oldest accepted address first
        if (pend_ready.size() > 0 && pend_ready[0] <= cyc) begin
            imem_resp.data_ok = 1'b1;
            imem_resp.rdata   = pend_addr.pop_front() ^ INST_MASK;
            void'(pend_ready.pop_front());
        end
        ds_allowin = ($urandom % 3) != 0;
    endtask

    task automatic observe_cycle();
        fetch_bundle_t exp_b;
        if (imem_req.req && imem_resp.addr_ok) begin
            pend_addr.push_back(imem_req.addr);
            // slower memory during redirect bursts
            pend_ready.push_back(cyc + (((cyc % 64) < 10) ? 32'd3 + ($urandom % 2)
                                                           : 32'd1 + ($urandom % 4)));
        end
        stall_count = exp_halted ? 0 : stall_count + 1;
        if (fs_to_ds_valid && ds_allowin) begin
            stall_count  = 0;
            bundles_seen = bundles_seen + 1;
            exp_b = (exp_pc[1:0] != 2'b00)
                ? fetch_bundle_t'{pc: exp_pc, inst: 32'd0, adef: 1'b1, ecode: `FETCH_ECODE_ADEF}
                : fetch_bundle_t'{pc: exp_pc, inst: exp_pc ^ INST_MASK, adef: 1'b0, ecode: 6'd0};
            if (exp_halted) begin
                other_errors = other_errors + 1;
                $display("bundle at pc %h reached decode after an address error",
                         fs_to_ds_bundle.pc);
            end else begin
                check_bundle("decode bundle", exp_b, fs_to_ds_bundle);
            end
            exp_halted = exp_b.adef;
            exp_pc     = exp_b.adef ? exp_pc : exp_pc + 32'd4;
        end
        if (redirect.excp_taken || redirect.ertn_taken || redirect.br_taken) begin
            exp_halted = 1'b0;
            // exception entry, then exception return, then branch
            exp_pc = redirect.excp_taken ? redirect.eentry
                   : redirect.ertn_taken ? redirect.era : redirect.br_target;
        end
        if (stall_count > STALL_LIMIT) begin
            other_errors = other_errors + 1;
            timed_out    = 1'b1;
            $display("timeout, no bundle reached decode in %0d cycles", STALL_LIMIT);
        end
    endtask

    initial begin
        void'($urandom(32'hbf6d6d72));
        reset        = 1'b1;
        redirect     = '0;
        imem_resp    = '0;
        ds_allowin   = 1'b0;
        cyc          = 32'd0;
        exp_pc       = `FETCH_RESET_PC;
        exp_halted   = 1'b0;
        timed_out    = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        bundles_seen = 0;
        stall_count  = 0;
        for (int i = 0; i < 15; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_quiet_in_reset();
        end
        // first loop edge is the 16th reset cycle
        for (int i = 0; i < NUM_CYCLES && !timed_out; i++) begin
            @(posedge clk);
            #1;
            reset = 1'b0;
            cyc   = cyc + 1;
            drive_inputs();
            @(negedge clk);
            observe_cycle();
        end
        if (bundles_seen < 100) begin
            other_errors = other_errors + 1;
            $display("only %0d bundles reached decode", bundles_seen);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, other_errors, u_dut.u_assert.fail_count);
        if (mismatches == 0 && other_errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* fetch_unit.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_req_fsm.sv
rtl/fetch_stale_cnt.sv
rtl/fetch_inst_buf.sv
rtl/fetch_unit.sv
verif/fetch_assert.sv
verif/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetch_tb -f fetch_unit.f -o fetch_sim \
    && ./obj_dir/fetch_sim +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
